// ==== common/cpu_cfg.svh ====
/* size settings of the integer issue slice
   included by both packages and by RTL that sizes arrays */
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// reservation station entries (at least 2)
`define RS_SIZE 4

// ROB tag width
`define NICK_WIDTH 4

// register and result width
`define DATA_WIDTH 32

`endif

// ==== common/isa_pkg.sv ====
/* operand word and ALU operation encodings
   shared by dispatch, the reservation station entries and the ALU */
`include "cpu_cfg.svh"

package isa_pkg;

    // one register, operand or result word
    typedef logic [`DATA_WIDTH-1:0] data_t;

    // integer ops handled by this slice
    typedef enum logic [3:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_AND  = 4'd2,
        OP_OR   = 4'd3,
        OP_XOR  = 4'd4,
        OP_SLL  = 4'd5,
        OP_SRL  = 4'd6,
        OP_SRA  = 4'd7,
        OP_SLT  = 4'd8,
        OP_SLTU = 4'd9,
        // upper immediate comes in on operand b
        OP_LUI  = 4'd10
    } alu_op_t;

endpackage

// ==== common/ooo_pkg.sv ====
/* rename tag and reservation station index types
   used by allocation, selection and result broadcast */
`include "cpu_cfg.svh"

package ooo_pkg;

    // ROB tag naming an in-flight result
    typedef logic [`NICK_WIDTH-1:0] nick_t;

    // index of one reservation station slot
    localparam int SLOT_WIDTH = $clog2(`RS_SIZE);

    typedef logic [SLOT_WIDTH-1:0] slot_t;

endpackage

// ==== hw/rs/rs_alloc.sv ====
/* places a dispatched instruction into the lowest free entry
   and forwards results broadcast in the same cycle */
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module rs_alloc import isa_pkg::*, ooo_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                rdy,
    input  logic                dp_en,
    input  alu_op_t             dp_op,
    input  data_t               dp_imm,
    input  logic                dp_use_imm,
    input  nick_t               dp_rd_nick,
    input  nick_t               dp_rs1_nick,
    input  data_t               dp_rs1_dt,
    input  logic                dp_rs1_rdy,
    input  nick_t               dp_rs2_nick,
    input  data_t               dp_rs2_dt,
    input  logic                dp_rs2_rdy,
    input  logic                cdb_en,
    input  nick_t               cdb_nick,
    input  data_t               cdb_dt,
    input  logic                lsb_en,
    input  nick_t               lsb_nick,
    input  data_t               lsb_dt,
    input  logic [`RS_SIZE-1:0] busy,
    input  logic [`RS_SIZE-1:0] grant,
    output logic                full,
    output logic [`RS_SIZE-1:0] load,
    output alu_op_t             ld_op,
    output data_t               ld_imm,
    output logic                ld_use_imm,
    output nick_t               ld_rd_nick,
    output nick_t               ld_rs1_nick,
    output data_t               ld_rs1_dt,
    output logic                ld_rs1_rdy,
    output nick_t               ld_rs2_nick,
    output data_t               ld_rs2_dt,
    output logic                ld_rs2_rdy
);

    logic [`RS_SIZE-1:0] free;
    slot_t               slot;
    logic                found;
    logic                rs1_cdb_hit;
    logic                rs1_lsb_hit;
    logic                rs2_cdb_hit;
    logic                rs2_lsb_hit;

    function automatic logic bus_hit(input logic en, input nick_t bus_nick,
                                     input logic src_rdy, input nick_t src_nick);
        return en && !src_rdy && (bus_nick == src_nick);
    endfunction

    // a slot being issued this cycle can take the new instruction
    assign free = ~busy | grant;

    always_comb begin
        slot  = '0;
        found = 1'b0;
        for (int i = `RS_SIZE - 1; i >= 0; i--) begin
            if (free[i]) begin
                slot  = slot_t'(i);
                found = 1'b1;
            end
        end
        load = '0;
        if (dp_en && found) begin
            load[slot] = 1'b1;
        end
    end

    assign full = ~found;

    // catch results that land on a bus while the instruction is in flight
    assign rs1_cdb_hit = bus_hit(cdb_en, cdb_nick, dp_rs1_rdy, dp_rs1_nick);
    assign rs1_lsb_hit = bus_hit(lsb_en, lsb_nick, dp_rs1_rdy, dp_rs1_nick);
    assign rs2_cdb_hit = bus_hit(cdb_en, cdb_nick, dp_rs2_rdy, dp_rs2_nick);
    assign rs2_lsb_hit = bus_hit(lsb_en, lsb_nick, dp_rs2_rdy, dp_rs2_nick);

    assign ld_rs1_dt  = rs1_cdb_hit ? cdb_dt : (rs1_lsb_hit ? lsb_dt : dp_rs1_dt);
    assign ld_rs1_rdy = dp_rs1_rdy | rs1_cdb_hit | rs1_lsb_hit;
    assign ld_rs2_dt  = rs2_cdb_hit ? cdb_dt : (rs2_lsb_hit ? lsb_dt : dp_rs2_dt);
    assign ld_rs2_rdy = dp_rs2_rdy | rs2_cdb_hit | rs2_lsb_hit;

    assign ld_op       = dp_op;
    assign ld_imm      = dp_imm;
    assign ld_use_imm  = dp_use_imm;
    assign ld_rd_nick  = dp_rd_nick;
    assign ld_rs1_nick = dp_rs1_nick;
    assign ld_rs2_nick = dp_rs2_nick;

    // upstream must respect full, which depends on entry state and the issue pick
    dispatch_when_full: assert property (@(posedge clk) disable iff (rst)
        (rdy && dp_en) |-> !full)
        else $error("dispatch while reservation station is full");

endmodule

// ==== hw/rs/rs_entry.sv ====
/* one reservation station slot
   holds an instruction until both sources arrive and it is issued */
`timescale 1ns/1ps

module rs_entry import isa_pkg::*, ooo_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    rdy,
    input  logic    clr,
    input  logic    load,
    input  alu_op_t ld_op,
    input  data_t   ld_imm,
    input  logic    ld_use_imm,
    input  nick_t   ld_rd_nick,
    input  nick_t   ld_rs1_nick,
    input  data_t   ld_rs1_dt,
    input  logic    ld_rs1_rdy,
    input  nick_t   ld_rs2_nick,
    input  data_t   ld_rs2_dt,
    input  logic    ld_rs2_rdy,
    input  logic    cdb_en,
    input  nick_t   cdb_nick,
    input  data_t   cdb_dt,
    input  logic    lsb_en,
    input  nick_t   lsb_nick,
    input  data_t   lsb_dt,
    input  logic    grant,
    output logic    busy,
    output logic    ready,
    output alu_op_t op,
    output data_t   imm,
    output logic    use_imm,
    output nick_t   rd_nick,
    output data_t   rs1_dt,
    output data_t   rs2_dt
);

    nick_t rs1_nick;
    nick_t rs2_nick;
    logic  rs1_rdy;
    logic  rs2_rdy;
    logic  rs1_cdb_hit;
    logic  rs1_lsb_hit;
    logic  rs2_cdb_hit;
    logic  rs2_lsb_hit;

    function automatic logic snoop(input logic en, input nick_t bus_nick,
                                   input logic src_rdy, input nick_t src_nick);
        return en && !src_rdy && (bus_nick == src_nick);
    endfunction

    assign rs1_cdb_hit = busy && snoop(cdb_en, cdb_nick, rs1_rdy, rs1_nick);
    assign rs1_lsb_hit = busy && snoop(lsb_en, lsb_nick, rs1_rdy, rs1_nick);
    assign rs2_cdb_hit = busy && snoop(cdb_en, cdb_nick, rs2_rdy, rs2_nick);
    assign rs2_lsb_hit = busy && snoop(lsb_en, lsb_nick, rs2_rdy, rs2_nick);

    assign ready = busy & rs1_rdy & rs2_rdy;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy    <= 1'b0;
            rs1_rdy <= 1'b0;
            rs2_rdy <= 1'b0;
        end else if (rdy) begin
            if (clr) begin
                busy <= 1'b0;
            end else if (load) begin
                // load wins over a grant of the previous occupant
                busy    <= 1'b1;
                rs1_rdy <= ld_rs1_rdy;
                rs2_rdy <= ld_rs2_rdy;
            end else begin
                if (grant) begin
                    busy <= 1'b0;
                end
                if (rs1_cdb_hit || rs1_lsb_hit) begin
                    rs1_rdy <= 1'b1;
                end
                if (rs2_cdb_hit || rs2_lsb_hit) begin
                    rs2_rdy <= 1'b1;
                end
            end
        end
    end

    // instruction payload and captured operands
    always_ff @(posedge clk) begin
        if (rdy) begin
            if (load) begin
                op       <= ld_op;
                imm      <= ld_imm;
                use_imm  <= ld_use_imm;
                rd_nick  <= ld_rd_nick;
                rs1_nick <= ld_rs1_nick;
                rs1_dt   <= ld_rs1_dt;
                rs2_nick <= ld_rs2_nick;
                rs2_dt   <= ld_rs2_dt;
            end else begin
                if (rs1_cdb_hit || rs1_lsb_hit) begin
                    rs1_dt <= rs1_cdb_hit ? cdb_dt : lsb_dt;
                end
                if (rs2_cdb_hit || rs2_lsb_hit) begin
                    rs2_dt <= rs2_cdb_hit ? cdb_dt : lsb_dt;
                end
            end
        end
    end

    // the selector must only pick slots with both operands present
    grant_needs_ready: assert property (@(posedge clk) disable iff (rst)
        grant |-> ready)
        else $error("grant to an entry that is not ready");

endmodule

// ==== hw/rs/rs_issue.sv ====
/* selects the lowest ready entry each cycle
   and presents its operation and operands to the ALU */
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module rs_issue import isa_pkg::*, ooo_pkg::*; (
    input  logic [`RS_SIZE-1:0] ready,
    input  alu_op_t             ent_op      [`RS_SIZE],
    input  data_t               ent_imm     [`RS_SIZE],
    input  logic                ent_use_imm [`RS_SIZE],
    input  nick_t               ent_rd_nick [`RS_SIZE],
    input  data_t               ent_rs1_dt  [`RS_SIZE],
    input  data_t               ent_rs2_dt  [`RS_SIZE],
    output logic [`RS_SIZE-1:0] grant,
    output logic                iss_en,
    output alu_op_t             iss_op,
    output data_t               iss_a,
    output data_t               iss_b,
    output nick_t               iss_nick
);

    slot_t sel;

    // lowest index has priority
    always_comb begin
        sel    = '0;
        iss_en = 1'b0;
        for (int i = `RS_SIZE - 1; i >= 0; i--) begin
            if (ready[i]) begin
                sel    = slot_t'(i);
                iss_en = 1'b1;
            end
        end
        grant = '0;
        if (iss_en) begin
            grant[sel] = 1'b1;
        end
    end

    assign iss_op   = ent_op[sel];
    assign iss_a    = ent_rs1_dt[sel];
    // immediate replaces rs2 for the I-type forms and LUI
    assign iss_b    = ent_use_imm[sel] ? ent_imm[sel] : ent_rs2_dt[sel];
    assign iss_nick = ent_rd_nick[sel];

    grant_onehot: assert #0 ($onehot0(grant))
        else $error("more than one entry granted");

endmodule

// ==== hw/alu.sv ====
/* integer ALU for the issue slice
   result and tag are registered and broadcast on the CDB */
`timescale 1ns/1ps

module alu import isa_pkg::*, ooo_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    rdy,
    input  logic    clr,
    input  logic    iss_en,
    input  alu_op_t iss_op,
    input  data_t   iss_a,
    input  data_t   iss_b,
    input  nick_t   iss_nick,
    output logic    cdb_en,
    output nick_t   cdb_nick,
    output data_t   cdb_dt
);

    logic [4:0] shamt;
    data_t      result;
    logic       cdb_vld;

    assign shamt = iss_b[4:0];

    always_comb begin
        case (iss_op)
            OP_ADD:  result = iss_a + iss_b;
            OP_SUB:  result = iss_a - iss_b;
            OP_AND:  result = iss_a & iss_b;
            OP_OR:   result = iss_a | iss_b;
            OP_XOR:  result = iss_a ^ iss_b;
            OP_SLL:  result = iss_a << shamt;
            OP_SRL:  result = iss_a >> shamt;
            OP_SRA:  result = data_t'($signed(iss_a) >>> shamt);
            OP_SLT:  result = data_t'($signed(iss_a) < $signed(iss_b));
            OP_SLTU: result = data_t'(iss_a < iss_b);
            OP_LUI:  result = iss_b;
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cdb_vld <= 1'b0;
        end else if (rdy) begin
            // a flush kills the result still waiting to broadcast
            if (clr) begin
                cdb_vld <= 1'b0;
            end else begin
                cdb_vld <= iss_en;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rdy && iss_en) begin
            cdb_nick <= iss_nick;
            cdb_dt   <= result;
        end
    end

    // held result shows again once rdy returns
    assign cdb_en = cdb_vld & rdy;

endmodule

// ==== hw/issue_unit.sv ====
/* integer issue and execute slice of the out-of-order core
   dispatch in, CDB out, woken by the CDB and the load buffer bus */
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module issue_unit import isa_pkg::*, ooo_pkg::*; (
    input  logic    clk_in,
    input  logic    rst,
    input  logic    rdy,
    input  logic    clr,
    input  logic    dp_en,
    input  alu_op_t dp_op,
    input  data_t   dp_imm,
    input  logic    dp_use_imm,
    input  nick_t   dp_rd_nick,
    input  nick_t   dp_rs1_nick,
    input  data_t   dp_rs1_dt,
    input  logic    dp_rs1_rdy,
    input  nick_t   dp_rs2_nick,
    input  data_t   dp_rs2_dt,
    input  logic    dp_rs2_rdy,
    output logic    full,
    input  logic    lsb_en,
    input  nick_t   lsb_nick,
    input  data_t   lsb_dt,
    output logic    cdb_en,
    output nick_t   cdb_nick,
    output data_t   cdb_dt
);

    wire [`RS_SIZE-1:0] busy;
    wire [`RS_SIZE-1:0] ready;
    wire [`RS_SIZE-1:0] grant;
    wire [`RS_SIZE-1:0] load;

    // allocation to entries
    wire alu_op_t ld_op;
    wire data_t   ld_imm;
    wire          ld_use_imm;
    wire nick_t   ld_rd_nick;
    wire nick_t   ld_rs1_nick;
    wire data_t   ld_rs1_dt;
    wire          ld_rs1_rdy;
    wire nick_t   ld_rs2_nick;
    wire data_t   ld_rs2_dt;
    wire          ld_rs2_rdy;

    // entries to selection
    wire alu_op_t ent_op      [`RS_SIZE];
    wire data_t   ent_imm     [`RS_SIZE];
    wire          ent_use_imm [`RS_SIZE];
    wire nick_t   ent_rd_nick [`RS_SIZE];
    wire data_t   ent_rs1_dt  [`RS_SIZE];
    wire data_t   ent_rs2_dt  [`RS_SIZE];

    // selection to ALU
    wire          iss_en;
    wire alu_op_t iss_op;
    wire data_t   iss_a;
    wire data_t   iss_b;
    wire nick_t   iss_nick;

    rs_alloc u_rs_alloc (
        .clk(clk_in),
        .rst(rst),
        .rdy(rdy),
        .dp_en(dp_en),
        .dp_op(dp_op),
        .dp_imm(dp_imm),
        .dp_use_imm(dp_use_imm),
        .dp_rd_nick(dp_rd_nick),
        .dp_rs1_nick(dp_rs1_nick),
        .dp_rs1_dt(dp_rs1_dt),
        .dp_rs1_rdy(dp_rs1_rdy),
        .dp_rs2_nick(dp_rs2_nick),
        .dp_rs2_dt(dp_rs2_dt),
        .dp_rs2_rdy(dp_rs2_rdy),
        .cdb_en(cdb_en),
        .cdb_nick(cdb_nick),
        .cdb_dt(cdb_dt),
        .lsb_en(lsb_en),
        .lsb_nick(lsb_nick),
        .lsb_dt(lsb_dt),
        .busy(busy),
        .grant(grant),
        .full(full),
        .load(load),
        .ld_op(ld_op),
        .ld_imm(ld_imm),
        .ld_use_imm(ld_use_imm),
        .ld_rd_nick(ld_rd_nick),
        .ld_rs1_nick(ld_rs1_nick),
        .ld_rs1_dt(ld_rs1_dt),
        .ld_rs1_rdy(ld_rs1_rdy),
        .ld_rs2_nick(ld_rs2_nick),
        .ld_rs2_dt(ld_rs2_dt),
        .ld_rs2_rdy(ld_rs2_rdy)
    );

    for (genvar g = 0; g < `RS_SIZE; g++) begin : g_entry
        rs_entry u_rs_entry (
            .clk(clk_in),
            .rst(rst),
            .rdy(rdy),
            .clr(clr),
            .load(load[g]),
            .ld_op(ld_op),
            .ld_imm(ld_imm),
            .ld_use_imm(ld_use_imm),
            .ld_rd_nick(ld_rd_nick),
            .ld_rs1_nick(ld_rs1_nick),
            .ld_rs1_dt(ld_rs1_dt),
            .ld_rs1_rdy(ld_rs1_rdy),
            .ld_rs2_nick(ld_rs2_nick),
            .ld_rs2_dt(ld_rs2_dt),
            .ld_rs2_rdy(ld_rs2_rdy),
            .cdb_en(cdb_en),
            .cdb_nick(cdb_nick),
            .cdb_dt(cdb_dt),
            .lsb_en(lsb_en),
            .lsb_nick(lsb_nick),
            .lsb_dt(lsb_dt),
            .grant(grant[g]),
            .busy(busy[g]),
            .ready(ready[g]),
            .op(ent_op[g]),
            .imm(ent_imm[g]),
            .use_imm(ent_use_imm[g]),
            .rd_nick(ent_rd_nick[g]),
            .rs1_dt(ent_rs1_dt[g]),
            .rs2_dt(ent_rs2_dt[g])
        );
    end

    rs_issue u_rs_issue (
        .ready(ready),
        .ent_op(ent_op),
        .ent_imm(ent_imm),
        .ent_use_imm(ent_use_imm),
        .ent_rd_nick(ent_rd_nick),
        .ent_rs1_dt(ent_rs1_dt),
        .ent_rs2_dt(ent_rs2_dt),
        .grant(grant),
        .iss_en(iss_en),
        .iss_op(iss_op),
        .iss_a(iss_a),
        .iss_b(iss_b),
        .iss_nick(iss_nick)
    );

    alu u_alu (
        .clk(clk_in),
        .rst(rst),
        .rdy(rdy),
        .clr(clr),
        .iss_en(iss_en),
        .iss_op(iss_op),
        .iss_a(iss_a),
        .iss_b(iss_b),
        .iss_nick(iss_nick),
        .cdb_en(cdb_en),
        .cdb_nick(cdb_nick),
        .cdb_dt(cdb_dt)
    );

endmodule

// ==== sim/tb_issue_unit.sv ====
/* directed testbench for the integer issue slice
   a scoreboard indexed by nick checks every CDB result, a cycle limit bounds the run */
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module tb_issue_unit import isa_pkg::*, ooo_pkg::*;;

    localparam int    NUM_TESTS       = 5;
    localparam int    CYCLES_PER_TEST = 40;
    localparam int    CYCLE_LIMIT     = NUM_TESTS * CYCLES_PER_TEST;
    // reserved for the load buffer, the ALU never produces it
    localparam nick_t LSB_NICK        = '1;

    logic    clk;
    logic    rst;
    logic    rdy;
    logic    clr;
    logic    dp_en;
    alu_op_t dp_op;
    data_t   dp_imm;
    logic    dp_use_imm;
    nick_t   dp_rd_nick;
    nick_t   dp_rs1_nick;
    data_t   dp_rs1_dt;
    logic    dp_rs1_rdy;
    nick_t   dp_rs2_nick;
    data_t   dp_rs2_dt;
    logic    dp_rs2_rdy;
    logic    full;
    logic    lsb_en;
    nick_t   lsb_nick;
    data_t   lsb_dt;
    logic    cdb_en;
    nick_t   cdb_nick;
    data_t   cdb_dt;

    // scoreboard
    data_t exp_dt  [2**`NICK_WIDTH];
    logic  exp_vld [2**`NICK_WIDTH];
    int    pending;
    int    cycle_count;
    nick_t next_nick;

    issue_unit u_dut (
        .clk_in(clk),
        .rst(rst),
        .rdy(rdy),
        .clr(clr),
        .dp_en(dp_en),
        .dp_op(dp_op),
        .dp_imm(dp_imm),
        .dp_use_imm(dp_use_imm),
        .dp_rd_nick(dp_rd_nick),
        .dp_rs1_nick(dp_rs1_nick),
        .dp_rs1_dt(dp_rs1_dt),
        .dp_rs1_rdy(dp_rs1_rdy),
        .dp_rs2_nick(dp_rs2_nick),
        .dp_rs2_dt(dp_rs2_dt),
        .dp_rs2_rdy(dp_rs2_rdy),
        .full(full),
        .lsb_en(lsb_en),
        .lsb_nick(lsb_nick),
        .lsb_dt(lsb_dt),
        .cdb_en(cdb_en),
        .cdb_nick(cdb_nick),
        .cdb_dt(cdb_dt)
    );

    always #50 clk = ~clk;

    task automatic abort_run();
        $display("Test failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_data(input string name, input data_t act, input data_t exp);
        if (act !== exp) begin
            $display("error: %s = 0x%h, expected 0x%h", name, act, exp);
            abort_run();
        end
    endtask

    task automatic check_nick(input string name, input nick_t act, input nick_t exp);
        if (act !== exp) begin
            $display("error: %s = 0x%h, expected 0x%h", name, act, exp);
            abort_run();
        end
    endtask

    // RV32I integer semantics
    function automatic data_t model_alu(input alu_op_t op, input data_t a, input data_t b);
        data_t r;
        case (op)
            OP_ADD:  r = a + b;
            OP_SUB:  r = a - b;
            OP_AND:  r = a & b;
            OP_OR:   r = a | b;
            OP_XOR:  r = a ^ b;
            OP_SLL:  r = a << b[4:0];
            OP_SRL:  r = a >> b[4:0];
            OP_SRA:  r = $unsigned($signed(a) >>> b[4:0]);
            OP_SLT:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            OP_SLTU: r = (a < b) ? 32'd1 : 32'd0;
            OP_LUI:  r = b;
            default: r = '0;
        endcase
        return r;
    endfunction

    task automatic take_nick(output nick_t n);
        n         = next_nick;
        next_nick = (next_nick == LSB_NICK - 1) ? '0 : next_nick + 1'b1;
    endtask

    task automatic expect_result(input nick_t n, input data_t v);
        exp_dt[n]  = v;
        exp_vld[n] = 1'b1;
        pending    = pending + 1;
    endtask

    // rs2 is always known, rs1 may wait on a nick
    task automatic dispatch(input alu_op_t op, input nick_t rd, input logic a_rdy,
                            input nick_t a_nick, input data_t a, input logic use_imm,
                            input data_t b);
        @(negedge clk);
        while (full) @(negedge clk);
        @(posedge clk);
        dp_en       <= 1'b1;
        dp_op       <= op;
        dp_rd_nick  <= rd;
        dp_rs1_rdy  <= a_rdy;
        dp_rs1_nick <= a_nick;
        dp_rs1_dt   <= a;
        dp_use_imm  <= use_imm;
        // the unused one carries the complement so a wrong mux shows up
        dp_imm      <= use_imm ? b : ~b;
        dp_rs2_dt   <= use_imm ? ~b : b;
        dp_rs2_rdy  <= 1'b1;
        dp_rs2_nick <= rd;
        @(posedge clk);
        dp_en <= 1'b0;
    endtask

    task automatic lsb_broadcast(input nick_t n, input data_t v);
        @(posedge clk);
        lsb_en   <= 1'b1;
        lsb_nick <= n;
        lsb_dt   <= v;
        @(posedge clk);
        lsb_en <= 1'b0;
    endtask

    task automatic wait_drain();
        while (pending != 0) @(posedge clk);
    endtask

    task automatic run_independent();
        nick_t   n;
        data_t   a;
        data_t   b;
        alu_op_t op;
        for (int i = 0; i <= int'(OP_LUI); i++) begin
            op = alu_op_t'(i);
            take_nick(n);
            a = $urandom();
            b = $urandom();
            expect_result(n, model_alu(op, a, b));
            dispatch(op, n, 1'b1, '0, a, i[0], b);
        end
        wait_drain();
    endtask

    task automatic run_chain();
        nick_t prev;
        nick_t n;
        nick_t prod;
        data_t val;
        data_t a;
        data_t b;
        data_t sub_b;
        take_nick(prev);
        a   = $urandom();
        b   = $urandom();
        val = model_alu(OP_ADD, a, b);
        expect_result(prev, val);
        dispatch(OP_ADD, prev, 1'b1, '0, a, 1'b0, b);
        // two-cycle dispatch spacing lines each one up with its producer on the CDB
        for (int k = 1; k < 5; k++) begin
            take_nick(n);
            b   = $urandom();
            val = model_alu(alu_op_t'(k), val, b);
            expect_result(n, val);
            dispatch(alu_op_t'(k), n, 1'b0, prev, $urandom(), k[0], b);
            prev = n;
        end
        wait_drain();
        // consumer goes in first and is woken from the CDB
        take_nick(prod);
        take_nick(n);
        a   = $urandom();
        b   = $urandom();
        val = model_alu(OP_XOR, a, b);
        expect_result(prod, val);
        sub_b = $urandom();
        expect_result(n, model_alu(OP_SUB, val, sub_b));
        dispatch(OP_SUB, n, 1'b0, prod, $urandom(), 1'b0, sub_b);
        dispatch(OP_XOR, prod, 1'b1, '0, a, 1'b1, b);
        wait_drain();
    endtask

    task automatic run_lsb_wakeup();
        nick_t n;
        data_t ld;
        data_t b;
        ld = $urandom();
        take_nick(n);
        b = $urandom();
        expect_result(n, model_alu(OP_ADD, ld, b));
        dispatch(OP_ADD, n, 1'b0, LSB_NICK, $urandom(), 1'b1, b);
        take_nick(n);
        b = $urandom();
        expect_result(n, model_alu(OP_SRA, ld, b));
        dispatch(OP_SRA, n, 1'b0, LSB_NICK, $urandom(), 1'b0, b);
        repeat (5) @(posedge clk);
        if (pending != 2) begin
            $display("a result reached the CDB before the load buffer broadcast");
            abort_run();
        end
        lsb_broadcast(LSB_NICK, ld);
        wait_drain();
    endtask

    task automatic run_capacity();
        nick_t n;
        data_t ld;
        data_t b;
        ld = $urandom();
        for (int i = 0; i < `RS_SIZE; i++) begin
            take_nick(n);
            b = $urandom();
            expect_result(n, model_alu(OP_OR, ld, b));
            dispatch(OP_OR, n, 1'b0, LSB_NICK, $urandom(), i[0], b);
        end
        @(negedge clk);
        if (!full) begin
            $display("full stayed low with every entry waiting");
            abort_run();
        end
        lsb_broadcast(LSB_NICK, ld);
        wait_drain();
        @(negedge clk);
        if (full) begin
            $display("full still high after every entry issued");
            abort_run();
        end
    endtask

    task automatic run_stall_flush();
        nick_t n;
        data_t a;
        data_t b;
        take_nick(n);
        a = $urandom();
        b = $urandom();
        expect_result(n, model_alu(OP_ADD, a, b));
        dispatch(OP_ADD, n, 1'b1, '0, a, 1'b0, b);
        // result sits in the ALU register from the next edge on
        @(posedge clk);
        rdy <= 1'b0;
        repeat (6) begin
            @(negedge clk);
            if (cdb_en) begin
                $display("cdb_en rose while rdy was low");
                abort_run();
            end
        end
        @(posedge clk);
        rdy <= 1'b1;
        do @(negedge clk); while (!cdb_en);
        check_nick("cdb_nick", cdb_nick, n);
        wait_drain();
        // flushed nicks get no expectation, so any broadcast of them fails
        for (int i = 0; i < `RS_SIZE; i++) begin
            take_nick(n);
            dispatch(OP_AND, n, 1'b0, LSB_NICK, $urandom(), 1'b0, $urandom());
        end
        @(posedge clk);
        clr <= 1'b1;
        @(posedge clk);
        clr <= 1'b0;
        @(negedge clk);
        if (full) begin
            $display("full still high after clr");
            abort_run();
        end
        lsb_broadcast(LSB_NICK, $urandom());
        repeat (6) @(posedge clk);
        take_nick(n);
        a = $urandom();
        b = $urandom();
        expect_result(n, model_alu(OP_SLTU, a, b));
        dispatch(OP_SLTU, n, 1'b1, '0, a, 1'b1, b);
        wait_drain();
    endtask

    // scoreboard check of every broadcast
    always @(negedge clk) begin
        if (!rst && cdb_en) begin
            if (!exp_vld[cdb_nick]) begin
                $display("unexpected cdb_en for nick %0d with nothing in flight", cdb_nick);
                abort_run();
            end else begin
                check_data("cdb_dt", cdb_dt, exp_dt[cdb_nick]);
                exp_vld[cdb_nick] = 1'b0;
                pending = pending - 1;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, %0d results never arrived", cycle_count,
                     pending);
            abort_run();
        end
    end

    initial begin
        void'($urandom(26));
        clk         = 1'b0;
        rst         = 1'b1;
        rdy         = 1'b1;
        clr         = 1'b0;
        dp_en       = 1'b0;
        dp_op       = OP_ADD;
        dp_imm      = '0;
        dp_use_imm  = 1'b0;
        dp_rd_nick  = '0;
        dp_rs1_nick = '0;
        dp_rs1_dt   = '0;
        dp_rs1_rdy  = 1'b0;
        dp_rs2_nick = '0;
        dp_rs2_dt   = '0;
        dp_rs2_rdy  = 1'b0;
        lsb_en      = 1'b0;
        lsb_nick    = '0;
        lsb_dt      = '0;
        pending     = 0;
        cycle_count = 0;
        next_nick   = '0;
        foreach (exp_vld[i]) exp_vld[i] = 1'b0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        if (full !== 1'b0 || cdb_en !== 1'b0) begin
            $display("full or cdb_en not low after reset");
            abort_run();
        end
        run_independent();
        run_chain();
        run_lsb_wakeup();
        run_capacity();
        run_stall_flush();
        $display("Test completed successfully");
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+common
common/isa_pkg.sv
common/ooo_pkg.sv
hw/rs/rs_alloc.sv
hw/rs/rs_entry.sv
hw/rs/rs_issue.sv
hw/alu.sv
hw/issue_unit.sv
sim/tb_issue_unit.sv

// ==== Bender.yml ====
package:
  name: issue_unit

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/isa_pkg.sv
      - common/ooo_pkg.sv
      - hw/rs/rs_alloc.sv
      - hw/rs/rs_entry.sv
      - hw/rs/rs_issue.sv
      - hw/alu.sv
      - hw/issue_unit.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - sim/tb_issue_unit.sv
